// ==== sim.f ====
rtl/routerPkg.sv
rtl/packetFramer.sv
rtl/routeFifo.sv
rtl/branchRouter.sv
rtl/routerTop.sv
sim/routerTb.sv

// ==== sim/routerStimulus.txt ====
# keyword and arguments: cmd kind data, drain level, reply branch kind data, expect channel kind data
# wait (compare all expected outputs), idle cycles, flag name value, id routerId
id 00b7
drain 1
flag protocolError 0
flag overflow 0
# Pass-through since destination 0042 is not ours
cmd hdr 12340042
cmd pay 11110001
cmd pay 11110002
cmd rls 000000ff
expect A req 12340042
expect A req 11110001
expect A req 11110002
expect A rls 000000ff
wait
# Local delivery with header halves swapped on B
cmd hdr 567800b7
cmd pay 22220001
cmd pay 22220002
cmd rls 00000002
expect B req 00b75678
expect B req 22220001
expect B req 22220002
expect B rls 00000002
wait
# Backward path while the release waits in the buffer
cmd hdr 9abc0011
expect A req 9abc0011
wait
drain 0
cmd rls 00000003
reply A req cafe0001
reply B req dead0001
reply A rls cafe0002
expect back req cafe0001
expect back rls cafe0002
wait
idle 4
wait
drain 1
expect A rls 00000003
wait
reply A req beef0001
idle 4
wait
# Buffering where eight words fill the FIFO and the ninth is dropped
drain 0
cmd hdr 44440001
cmd pay 44440011
cmd pay 44440012
cmd pay 44440013
cmd pay 44440014
cmd pay 44440015
cmd pay 44440016
cmd rls 00000004
idle 3
flag fifoFull 1
flag overflow 0
cmd hdr 55550001
idle 3
flag overflow 1
expect A req 44440001
expect A req 44440011
expect A req 44440012
expect A req 44440013
expect A req 44440014
expect A req 44440015
expect A req 44440016
expect A rls 00000004
drain 1
wait
flag fifoFull 0
# The framer is still open from the dropped header, this release finds no route
cmd rls 00000000
idle 4
wait
# Command order with a payload while idle
cmd pay 77770001
idle 3
flag protocolError 1
wait
cmd hdr 888800b7
cmd pay 88880001
cmd rls 00000005
expect B req 00b78888
expect B req 88880001
expect B rls 00000005
wait
idle 8
wait

// ==== sim/routerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerTb;

	import routerPkg::*;

	localparam int CLOCK_PERIOD    = 8;
	localparam int RESET_CYCLES    = 16;
	localparam int CYCLES_PER_LINE = 200;		// Watchdog budget per stimulus line

	typedef logic [8*16-1:0] token_t;			// One word of the stimulus file

	logic					clock;
	logic					reset;
	logic					cmdStrobe;
	wordKind_t				cmdKind;
	logic [WIDTH_DATA-1:0]	cmdData;
	logic					protocolError;
	logic					drainEnable;
	logic					fifoFull;
	logic					overflow;
	logic [WIDTH_ID-1:0]	routerId;
	logic					reqA;
	logic					rlsA;
	logic [WIDTH_DATA-1:0]	dataA;
	logic					branchReqA;
	logic					branchRlsA;
	logic [WIDTH_DATA-1:0]	branchDataA;
	logic					reqB;
	logic					rlsB;
	logic [WIDTH_DATA-1:0]	dataB;
	logic					branchReqB;
	logic					branchRlsB;
	logic [WIDTH_DATA-1:0]	branchDataB;
	logic					backReq;
	logic					backRls;
	logic [WIDTH_DATA-1:0]	backData;

	logic [WIDTH_DATA:0]	expA [$];		// {release, data}
	logic [WIDTH_DATA:0]	expB [$];
	logic [WIDTH_DATA:0]	expBack [$];
	logic [WIDTH_DATA:0]	obsA [$];
	logic [WIDTH_DATA:0]	obsB [$];
	logic [WIDTH_DATA:0]	obsBack [$];
	int						errorCount = 0;
	int						watchCycles = 0;

	routerTop u_routerTop (.*);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD/2) clock = ~clock;
	end

	////////////////////////////////////////
	// Monitors

	always @(posedge clock) begin
		if (!reset && (reqA || rlsA)) obsA.push_back({rlsA, dataA});
	end

	always @(posedge clock) begin
		if (!reset && (reqB || rlsB)) obsB.push_back({rlsB, dataB});
	end

	always @(posedge clock) begin
		if (!reset && (backReq || backRls)) obsBack.push_back({backRls, backData});
	end

	////////////////////////////////////////
	// Checks and failure

	task automatic abortRun(input string why);
		errorCount++;
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			abortRun($sformatf("mismatch time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual));
		end
	endtask

	task automatic compareWord(input string kindName, input string dataName,
			input logic [WIDTH_DATA:0] expected, input logic [WIDTH_DATA:0] actual);
		check(kindName, 32'(expected[WIDTH_DATA]), 32'(actual[WIDTH_DATA]));	// 1 is release
		check(dataName, expected[WIDTH_DATA-1:0], actual[WIDTH_DATA-1:0]);
	endtask

	// Blocks until every channel has at least as many words as expected
	task automatic waitForOutputs;
		while (obsA.size() < expA.size() || obsB.size() < expB.size()
				|| obsBack.size() < expBack.size()) begin
			@(negedge clock);
		end
		while (expA.size() != 0) begin
			compareWord("rlsA", "dataA", expA.pop_front(), obsA.pop_front());
		end
		while (expB.size() != 0) begin
			compareWord("rlsB", "dataB", expB.pop_front(), obsB.pop_front());
		end
		while (expBack.size() != 0) begin
			compareWord("backRls", "backData", expBack.pop_front(), obsBack.pop_front());
		end
		if (obsA.size() != 0) abortRun("unexpected request or release on branch A");
		if (obsB.size() != 0) abortRun("unexpected request or release on branch B");
		if (obsBack.size() != 0) abortRun("unexpected request or release on the backward path");
	endtask

	////////////////////////////////////////
	// Stimulus actions

	task automatic sendCommand(input token_t kind, input logic [31:0] data);
		@(negedge clock);
		if (kind == "hdr") cmdKind = kindHeader;
		else if (kind == "pay") cmdKind = kindPayload;
		else if (kind == "rls") cmdKind = kindRelease;
		else abortRun("command with an unknown kind in the stimulus file");
		cmdData   = data;
		cmdStrobe = 1'b1;
		@(negedge clock);
		cmdStrobe = 1'b0;
	endtask

	task automatic sendReply(input token_t branch, input token_t kind, input logic [31:0] data);
		@(negedge clock);
		if (branch == "A") begin
			branchReqA  = (kind == "req");
			branchRlsA  = (kind == "rls");
			branchDataA = data;
		end
		else if (branch == "B") begin
			branchReqB  = (kind == "req");
			branchRlsB  = (kind == "rls");
			branchDataB = data;
		end
		else begin
			abortRun("reply names an unknown branch");
		end
		@(negedge clock);
		branchReqA = 1'b0;
		branchRlsA = 1'b0;
		branchReqB = 1'b0;
		branchRlsB = 1'b0;
	endtask

	task automatic addExpectation(input token_t chan, input token_t kind, input logic [31:0] data);
		logic [WIDTH_DATA:0] word;
		if (kind != "req" && kind != "rls") abortRun("expectation with an unknown kind");
		word = {(kind == "rls"), data};
		if (chan == "A") expA.push_back(word);
		else if (chan == "B") expB.push_back(word);
		else if (chan == "back") expBack.push_back(word);
		else abortRun("expectation names an unknown channel");
	endtask

	task automatic checkFlag(input token_t name, input int value);
		@(negedge clock);
		if (name == "protocolError") check("protocolError", 32'(value), 32'(protocolError));
		else if (name == "fifoFull") check("fifoFull", 32'(value), 32'(fifoFull));
		else if (name == "overflow") check("overflow", 32'(value), 32'(overflow));
		else abortRun("flag check names an unknown status output");
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		int					fd;
		int					r;
		int					lineCount;
		int					number;
		token_t				op;
		token_t				arg1;
		token_t				arg2;
		logic [31:0]		value;
		logic [8*128-1:0]	lineText;
		reset       = 1'b1;
		cmdStrobe   = 1'b0;
		cmdKind     = kindHeader;
		cmdData     = '0;
		drainEnable = 1'b0;
		routerId    = '0;
		branchReqA  = 1'b0;
		branchRlsA  = 1'b0;
		branchDataA = '0;
		branchReqB  = 1'b0;
		branchRlsB  = 1'b0;
		branchDataB = '0;
		lineCount   = 0;
		fd = $fopen("sim/routerStimulus.txt", "r");
		if (fd == 0) abortRun("cannot open sim/routerStimulus.txt");
		while (!$feof(fd)) begin
			r = $fgets(lineText, fd);
			if (r != 0) lineCount++;
		end
		$fclose(fd);
		watchCycles = lineCount * CYCLES_PER_LINE + RESET_CYCLES;	// Starts the watchdog
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		fd = $fopen("sim/routerStimulus.txt", "r");
		r = $fscanf(fd, "%s", op);
		while (r == 1) begin
			if (op == "#") r = $fgets(lineText, fd);		// Comment line
			else if (op == "id") begin
				r = $fscanf(fd, "%h", value);
				@(negedge clock);
				routerId = value[WIDTH_ID-1:0];
			end
			else if (op == "drain") begin
				r = $fscanf(fd, "%d", number);
				@(negedge clock);
				drainEnable = (number != 0);
			end
			else if (op == "cmd") begin
				r = $fscanf(fd, "%s %h", arg1, value);
				sendCommand(arg1, value);
			end
			else if (op == "reply") begin
				r = $fscanf(fd, "%s %s %h", arg1, arg2, value);
				sendReply(arg1, arg2, value);
			end
			else if (op == "expect") begin
				r = $fscanf(fd, "%s %s %h", arg1, arg2, value);
				addExpectation(arg1, arg2, value);
			end
			else if (op == "flag") begin
				r = $fscanf(fd, "%s %d", arg1, number);
				checkFlag(arg1, number);
			end
			else if (op == "idle") begin
				r = $fscanf(fd, "%d", number);
				repeat (number) @(negedge clock);
			end
			else if (op == "wait") waitForOutputs();
			else abortRun($sformatf("unknown keyword %0s in the stimulus file", op));
			r = $fscanf(fd, "%s", op);
		end
		$fclose(fd);
		if (errorCount == 0) begin
			$display("TEST PASS");
		end
		else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		wait (watchCycles > 0);
		repeat (watchCycles) @(posedge clock);
		abortRun("timeout: the expected outputs never arrived");
	end

endmodule

`default_nettype wire

// ==== rtl/routerTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerTop (
	input  wire logic								clock,
	input  wire logic								reset,
	// Command input
	input  wire logic								cmdStrobe,
	input  wire routerPkg::wordKind_t				cmdKind,
	input  wire logic [routerPkg::WIDTH_DATA-1:0]	cmdData,
	output logic									protocolError,
	// Buffer control and status
	input  wire logic								drainEnable,
	output logic									fifoFull,
	output logic									overflow,
	// Router configuration
	input  wire logic [routerPkg::WIDTH_ID-1:0]		routerId,
	// Branch A
	output logic									reqA,
	output logic									rlsA,
	output logic [routerPkg::WIDTH_DATA-1:0]		dataA,
	input  wire logic								branchReqA,
	input  wire logic								branchRlsA,
	input  wire logic [routerPkg::WIDTH_DATA-1:0]	branchDataA,
	// Branch B
	output logic									reqB,
	output logic									rlsB,
	output logic [routerPkg::WIDTH_DATA-1:0]		dataB,
	input  wire logic								branchReqB,
	input  wire logic								branchRlsB,
	input  wire logic [routerPkg::WIDTH_DATA-1:0]	branchDataB,
	// Backward path
	output logic									backReq,
	output logic									backRls,
	output logic [routerPkg::WIDTH_DATA-1:0]		backData
);

	import routerPkg::*;

	logic					pushStrobe;		// Framer to FIFO
	wordKind_t				pushKind;
	logic [WIDTH_DATA-1:0]	pushData;
	logic					fwdReq;			// FIFO to router
	logic					fwdRls;
	logic [WIDTH_DATA-1:0]	fwdData;

	packetFramer u_packetFramer (
		.clock, .reset, .cmdStrobe, .cmdKind, .cmdData,
		.pushStrobe, .pushKind, .pushData, .protocolError
	);

	routeFifo u_routeFifo (
		.clock, .reset, .pushStrobe, .pushKind, .pushData, .drainEnable,
		.fwdReq, .fwdRls, .fwdData, .fifoFull, .overflow
	);

	branchRouter u_branchRouter (
		.clock, .reset, .routerId, .fwdReq, .fwdRls, .fwdData,
		.reqA, .rlsA, .dataA, .reqB, .rlsB, .dataB,
		.branchReqA, .branchRlsA, .branchDataA,
		.branchReqB, .branchRlsB, .branchDataB,
		.backReq, .backRls, .backData
	);

endmodule

`default_nettype wire

// ==== rtl/branchRouter.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchRouter (
	input  wire logic								clock,
	input  wire logic								reset,
	input  wire logic [routerPkg::WIDTH_ID-1:0]		routerId,		// Own ID, static
	// Forward path from the FIFO
	input  wire logic								fwdReq,
	input  wire logic								fwdRls,
	input  wire logic [routerPkg::WIDTH_DATA-1:0]	fwdData,
	// Branch outputs
	output logic									reqA,
	output logic									rlsA,
	output logic [routerPkg::WIDTH_DATA-1:0]		dataA,
	output logic									reqB,
	output logic									rlsB,
	output logic [routerPkg::WIDTH_DATA-1:0]		dataB,
	// Branch replies
	input  wire logic								branchReqA,
	input  wire logic								branchRlsA,
	input  wire logic [routerPkg::WIDTH_DATA-1:0]	branchDataA,
	input  wire logic								branchReqB,
	input  wire logic								branchRlsB,
	input  wire logic [routerPkg::WIDTH_DATA-1:0]	branchDataB,
	// Backward path
	output logic									backReq,
	output logic									backRls,
	output logic [routerPkg::WIDTH_DATA-1:0]		backData
);

	import routerPkg::*;

	logic					run;			// Message open
	logic					matchReg;		// Route latched at the header
	logic					isMatch;
	logic					isHeader;
	logic					toB;
	logic					sendA;
	logic					sendB;
	logic					replyReq;
	logic					replyRls;
	logic [WIDTH_DATA-1:0]	replyData;

	////////////////////////////////////////
	// Route decision

	assign isMatch  = (fwdData[WIDTH_ID-1:0] == routerId);		// Destination in low half
	assign isHeader = fwdReq && !run;							// First request while idle
	assign toB      = run ? matchReg : isMatch;
	assign sendA    = (fwdReq || (fwdRls && run)) && !toB;
	assign sendB    = (fwdReq || (fwdRls && run)) && toB;

	always_ff @(posedge clock) begin
		if (reset) begin
			run      <= 1'b0;
			matchReg <= 1'b0;
		end
		else if (fwdRls) begin
			run <= 1'b0;					// Route closes at release
		end
		else if (isHeader) begin
			run      <= 1'b1;
			matchReg <= isMatch;
		end
	end

	////////////////////////////////////////
	// Forward to branches

	always_ff @(posedge clock) begin
		if (reset) begin
			reqA <= 1'b0;
			rlsA <= 1'b0;
			reqB <= 1'b0;
			rlsB <= 1'b0;
		end
		else begin
			reqA <= fwdReq && !toB;
			rlsA <= fwdRls && run && !matchReg;
			reqB <= fwdReq && toB;
			rlsB <= fwdRls && run && matchReg;
		end
	end

	always_ff @(posedge clock) begin
		if (sendA) dataA <= fwdData;
		if (sendB) begin
			// Local header gets its halves swapped
			dataB <= isHeader ? {fwdData[WIDTH_ID-1:0], fwdData[WIDTH_DATA-1:WIDTH_ID]}
			                  : fwdData;
		end
	end

	////////////////////////////////////////
	// Backward path from the chosen branch only

	assign replyReq  = matchReg ? branchReqB  : branchReqA;
	assign replyRls  = matchReg ? branchRlsB  : branchRlsA;
	assign replyData = matchReg ? branchDataB : branchDataA;

	always_ff @(posedge clock) begin
		if (reset) begin
			backReq <= 1'b0;
			backRls <= 1'b0;
		end
		else begin
			backReq <= run && replyReq;		// Idle keeps backward quiet
			backRls <= run && replyRls;
		end
	end

	always_ff @(posedge clock) begin
		if (run && (replyReq || replyRls)) backData <= replyData;
	end

	assert property (@(posedge clock) disable iff (reset) !(reqA && reqB))
		else $error("branchRouter: both branches requested");

endmodule

`default_nettype wire

// ==== rtl/routeFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module routeFifo (
	input  wire logic								clock,
	input  wire logic								reset,
	input  wire logic								pushStrobe,
	input  wire routerPkg::wordKind_t				pushKind,
	input  wire logic [routerPkg::WIDTH_DATA-1:0]	pushData,
	input  wire logic								drainEnable,	// One pop per cycle while high
	output logic									fwdReq,			// Header or payload out
	output logic									fwdRls,			// Release out
	output logic [routerPkg::WIDTH_DATA-1:0]		fwdData,
	output logic									fifoFull,
	output logic									overflow		// Sticky
);

	import routerPkg::*;

	wordKind_t				kindMem [FIFO_DEPTH];
	logic [WIDTH_DATA-1:0]	dataMem [FIFO_DEPTH];
	logic [FIFO_ADDR-1:0]	wrPtr;
	logic [FIFO_ADDR-1:0]	rdPtr;
	logic [FIFO_ADDR:0]		count;
	logic					doPush;
	logic					doPop;

	assign fifoFull = (count == (FIFO_ADDR+1)'(FIFO_DEPTH));
	assign doPush   = pushStrobe && !fifoFull;		// Full drops the word
	assign doPop    = drainEnable && (count != '0);

	always_ff @(posedge clock) begin
		if (doPush) begin
			kindMem[wrPtr] <= pushKind;
			dataMem[wrPtr] <= pushData;
		end
	end

	////////////////////////////////////////
	// Pointers and fill level

	always_ff @(posedge clock) begin
		if (reset) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else begin
			if (doPush) wrPtr <= wrPtr + 1'b1;
			if (doPop)  rdPtr <= rdPtr + 1'b1;
			count <= count + (FIFO_ADDR+1)'(doPush) - (FIFO_ADDR+1)'(doPop);
			if (pushStrobe && fifoFull) begin
				overflow <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Popped word into router strobes

	always_ff @(posedge clock) begin
		if (reset) begin
			fwdReq <= 1'b0;
			fwdRls <= 1'b0;
		end
		else begin
			fwdReq <= doPop && (kindMem[rdPtr] != kindRelease);
			fwdRls <= doPop && (kindMem[rdPtr] == kindRelease);
		end
	end

	always_ff @(posedge clock) begin
		if (doPop) fwdData <= dataMem[rdPtr];
	end

	assert property (@(posedge clock) disable iff (reset) count <= FIFO_DEPTH)
		else $error("routeFifo: fill level above depth");
	assert property (@(posedge clock) disable iff (reset) !(fwdReq && fwdRls))
		else $error("routeFifo: request and release in the same cycle");

endmodule

`default_nettype wire

// ==== rtl/packetFramer.sv ====
`timescale 1ns/1ps
`default_nettype none

module packetFramer (
	input  wire logic								clock,
	input  wire logic								reset,
	input  wire logic								cmdStrobe,		// Command valid pulse
	input  wire routerPkg::wordKind_t				cmdKind,		// Command opcode
	input  wire logic [routerPkg::WIDTH_DATA-1:0]	cmdData,
	output logic									pushStrobe,		// Word valid for the FIFO
	output routerPkg::wordKind_t					pushKind,
	output logic [routerPkg::WIDTH_DATA-1:0]		pushData,
	output logic									protocolError	// Sticky
);

	import routerPkg::*;

	framerState_t	state;
	framerState_t	stateNext;
	logic			cmdLegal;

	////////////////////////////////////////
	// Command order check

	always_comb begin
		cmdLegal  = 1'b0;
		stateNext = state;
		case (state)
			stateIdle: begin
				if (cmdKind == kindHeader) begin			// Only a header opens
					cmdLegal  = cmdStrobe;
					stateNext = cmdStrobe ? stateOpen : stateIdle;
				end
			end
			stateOpen: begin
				if (cmdKind == kindPayload) begin
					cmdLegal = cmdStrobe;
				end
				else if (cmdKind == kindRelease) begin
					cmdLegal  = cmdStrobe;
					stateNext = cmdStrobe ? stateIdle : stateOpen;
				end
			end
			default: begin
				stateNext = stateIdle;
			end
		endcase
	end

	////////////////////////////////////////
	// Registered push port

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= stateIdle;
			pushStrobe    <= 1'b0;
			protocolError <= 1'b0;
		end
		else begin
			state      <= stateNext;
			pushStrobe <= cmdLegal;
			if (cmdStrobe && !cmdLegal) begin
				protocolError <= 1'b1;			// Out of order, word dropped
			end
		end
	end

	always_ff @(posedge clock) begin
		if (cmdLegal) begin
			pushKind <= cmdKind;
			pushData <= cmdData;
		end
	end

	////////////////////////////////////////
	// Checks

	// A header leaves the framer only if the message was closed when it came in
	property headerFromIdle;
		@(posedge clock) disable iff (reset)
		(pushStrobe && pushKind == kindHeader) |-> ($past(state) == stateIdle);
	endproperty
	assert property (headerFromIdle)
		else $error("packetFramer: header pushed while a message was open");

endmodule

`default_nettype wire

// ==== rtl/routerPkg.sv ====
`default_nettype none

package routerPkg;

	////////////////////////////////////////
	// Sizes

	localparam int WIDTH_DATA = 32;					// Data word
	localparam int WIDTH_ID   = WIDTH_DATA / 2;		// Router ID and destination field
	localparam int FIFO_DEPTH = 8;					// Buffer entries
	localparam int FIFO_ADDR  = 3;					// Pointer width, log2 of depth

	////////////////////////////////////////
	// Encodings

	// Word kind, command opcode at the top input and FIFO tag
	typedef enum logic [1:0] {
		kindHeader  = 2'd0,
		kindPayload = 2'd1,
		kindRelease = 2'd2
	} wordKind_t;

	// Framer message state
	typedef enum logic {
		stateIdle = 1'b0,						// Waiting for a header
		stateOpen = 1'b1						// Header seen, release pending
	} framerState_t;

endpackage

`default_nettype wire
